//--- source/upd77c25Pkg.sv
`default_nettype none

package upd77c25Pkg;

  ////////////////////
  // widths
  localparam int wordWidth = 16; // data word
  localparam int insnWidth = 24; // program word

  // instruction class, top two bits
  typedef enum logic [1:0] {
    kindOp = 2'd0,
    kindRt = 2'd1, // no stack in this core, runs as a plain OP
    kindJp = 2'd2,
    kindLd = 2'd3
  } opKind_t;

  // alu codes kept in the reduced core, the rest decode as no-op
  typedef enum logic [3:0] {
    aluNone = 4'd0,
    aluOr   = 4'd1,
    aluAnd  = 4'd2,
    aluXor  = 4'd3,
    aluSub  = 4'd4,
    aluAdd  = 4'd5,
    aluDec  = 4'd8,  // q - 1
    aluInc  = 4'd9,  // q + 1
    aluNot  = 4'd10,
    aluShr1 = 4'd11  // arithmetic shift right
  } aluOp_t;

  // source / destination register codes
  typedef enum logic [3:0] {
    regNon   = 4'd0,
    regA     = 4'd1,
    regB     = 4'd2,
    regTr    = 4'd3,
    regDr    = 4'd6,  // dst only
    regSr    = 4'd7,  // dst only, just DRC is writable
    regDrSrc = 4'd8,  // src, also raises RQM
    regSrSrc = 4'd10  // src
  } regSel_t;

  // branch field of JP
  typedef enum logic [8:0] {
    condJmp   = 9'b100_000_000,
    condJnca  = 9'b010_000_000,
    condJca   = 9'b010_000_010,
    condJnza  = 9'b010_001_000,
    condJza   = 9'b010_001_010,
    condJnrqm = 9'b010_111_100,
    condJrqm  = 9'b010_111_110
  } jumpCond_t;

  ////////////////////
  // instruction views, all 24 bits
  typedef struct packed {
    opKind_t    kind;
    logic [1:0] pselect; // multiplier select on the full chip, ignored
    aluOp_t     alu;
    logic       asl;     // 0 = A, 1 = B
    logic [6:0] spare;   // dp / rp modifiers, not implemented
    regSel_t    src;
    regSel_t    dst;
  } insn_t;

  typedef struct packed {
    opKind_t     kind;
    jumpCond_t   brch;
    logic [10:0] na;    // jump target
    logic [1:0]  spare;
  } jpView_t;

  typedef struct packed {
    opKind_t              kind;
    logic [wordWidth-1:0] id;  // immediate
    logic [1:0]           spare;
    regSel_t              dst;
  } ldView_t;

  // per-accumulator flags
  typedef struct packed {
    logic c;
    logic z;
    logic s0;
  } aluFlags_t;

  // destination write issued in STORE
  typedef struct packed {
    logic                 valid;
    regSel_t              dst;
    logic [wordWidth-1:0] value;
  } dstWrite_t;

  // status register bits
  localparam int srRqm = 15;
  localparam int srDrs = 12;
  localparam int srDrc = 10;

endpackage

`default_nettype wire

//--- source/upd77c25PgmRom.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25PgmRom import upd77c25Pkg::*; #(
  parameter int pgmAddrWidth = 11
) (
  input  wire logic                    CLK,
  input  wire logic                    pgmWr,   // host load, only while in reset
  input  wire logic [pgmAddrWidth-1:0] pgmAddr,
  input  wire insn_t                   pgmData,
  input  wire logic [pgmAddrWidth-1:0] pc,
  output insn_t                        insn
);

  // one word per program address
  logic [insnWidth-1:0] mem [2**pgmAddrWidth];

  // write port, host side
  always_ff @(posedge CLK) begin
    if (pgmWr) mem[pgmAddr] <= pgmData;
  end

  // read port, one cycle latency, valid in FETCH
  always_ff @(posedge CLK) begin
    insn <= insn_t'(mem[pc]);
  end

endmodule

`default_nettype wire

//--- source/upd77c25HostPort.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25HostPort import upd77c25Pkg::*; (
  input  wire logic                 CLK,
  input  wire logic                 rst,
  input  wire logic                 enable,
  input  wire logic                 a0,          // 1 = SR, 0 = DR
  input  wire logic                 regWeRising, // host write strobe
  input  wire logic                 regOeRising, // end of host read
  input  wire logic [7:0]           dataIn,
  input  wire dstWrite_t            store,
  input  wire logic                 rqmSet,
  output logic      [7:0]           dataOut,
  output logic      [wordWidth-1:0] dr,
  output logic      [wordWidth-1:0] sr
);

  logic rqm;
  logic drs; // 1 = high byte next
  logic drc; // 1 = 8-bit transfers
  logic hostDrWr;
  logic hostDrRd;
  logic hostDrAcc;

  assign hostDrWr  = enable & regWeRising & ~a0;
  assign hostDrRd  = enable & regOeRising & ~a0;
  assign hostDrAcc = hostDrWr | hostDrRd;

  ////////////////////
  // handshake bits
  always_ff @(posedge CLK) begin
    if (rst) begin
      rqm <= 1'b0;
      drs <= 1'b0;
    end else begin
      if (hostDrAcc) begin
        if (drc || drs) rqm <= 1'b0; // word complete
      end else if (rqmSet) begin
        rqm <= 1'b1; // host strobe has priority
      end
      if (hostDrAcc && !drc) drs <= ~drs;
    end
  end

  // DRC is the only SR bit the program can write
  always_ff @(posedge CLK) begin
    if (rst) drc <= 1'b0;
    else if (store.valid && store.dst == regSr) drc <= store.value[srDrc];
  end

  ////////////////////
  // data register
  always_ff @(posedge CLK) begin
    if (rst) begin
      dr <= '0;
    end else if (hostDrWr) begin
      if (drc || !drs) dr[7:0] <= dataIn; // low byte first
      else dr[15:8] <= dataIn;
    end else if (store.valid && store.dst == regDr) begin
      dr <= store.value;
    end
  end

  always_comb begin
    sr        = '0;
    sr[srRqm] = rqm;
    sr[srDrs] = drs;
    sr[srDrc] = drc;
  end

  // host read mux
  assign dataOut = a0 ? sr[15:8] : ((drc || !drs) ? dr[7:0] : dr[15:8]);

  // a DR strobe always beats a DSP-side set
  rqmHostWins: assert property (@(posedge CLK) disable iff (rst)
    hostDrAcc |=> !$rose(rqm));

endmodule

`default_nettype wire

//--- source/upd77c25Sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25Sequencer import upd77c25Pkg::*; #(
  parameter int pgmAddrWidth = 11
) (
  input  wire logic                    CLK,
  input  wire logic                    rst,
  input  wire insn_t                   insnRaw, // program memory output
  input  wire logic [wordWidth-1:0]    accA,
  input  wire logic [wordWidth-1:0]    accB,
  input  wire logic [wordWidth-1:0]    tr,
  input  wire logic [wordWidth-1:0]    dr,
  input  wire logic [wordWidth-1:0]    sr,
  input  wire aluFlags_t               flagsA,
  output logic      [pgmAddrWidth-1:0] pc,
  output insn_t                        insn,
  output logic      [wordWidth-1:0]    idb,       // internal data bus
  output logic                         phaseExec,
  output logic                         phaseNext,
  output dstWrite_t                    store,
  output logic                         rqmSet
);

  typedef enum logic [4:0] {
    stFetch = 5'b00001,
    stLoad  = 5'b00010,
    stExec  = 5'b00100,
    stStore = 5'b01000,
    stNext  = 5'b10000
  } state_t;

  state_t  state;
  jpView_t jp;
  ldView_t ld;
  logic    jumpTaken;
  logic    condTrue; // latched in EXEC
  logic    isOp;     // OP or RT

  assign jp   = jpView_t'(insn);
  assign ld   = ldView_t'(insn);
  assign isOp = (insn.kind == kindOp) || (insn.kind == kindRt);

  ////////////////////
  // five-state FSM and PC
  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= stNext; // first FETCH one cycle after reset
      insn     <= '0;
      pc       <= '0;
      condTrue <= 1'b0;
    end else begin
      case (state)
        stFetch: begin
          state <= stLoad;
          insn  <= insnRaw;
        end
        stLoad: state <= stExec;
        stExec: begin
          state    <= stStore;
          condTrue <= jumpTaken;
        end
        stStore: begin
          state <= stNext;
          if (insn.kind == kindJp && condTrue) pc <= jp.na[pgmAddrWidth-1:0];
          else pc <= pc + 1'b1;
        end
        default: state <= stFetch; // NEXT
      endcase
    end
  end

  // jump conditions, only A flags and RQM survive
  always_comb begin
    case (jp.brch)
      condJmp:   jumpTaken = 1'b1;
      condJnca:  jumpTaken = !flagsA.c;
      condJca:   jumpTaken = flagsA.c;
      condJnza:  jumpTaken = !flagsA.z;
      condJza:   jumpTaken = flagsA.z;
      condJnrqm: jumpTaken = !sr[srRqm];
      condJrqm:  jumpTaken = sr[srRqm];
      default:   jumpTaken = 1'b0;
    endcase
  end

  ////////////////////
  // source bus, loaded in LOAD
  always_ff @(posedge CLK) begin
    if (state == stLoad) begin
      if (insn.kind == kindLd) begin
        idb <= ld.id;
      end else if (isOp) begin
        case (insn.src)
          regA:     idb <= accA;
          regB:     idb <= accB;
          regTr:    idb <= tr;
          regDrSrc: idb <= dr;
          regSrSrc: idb <= sr;
          default:  idb <= '0;
        endcase
      end
    end
  end

  assign phaseExec = (state == stExec);
  assign phaseNext = (state == stNext);

  // LD keeps its destination in the same bits as OP
  always_comb begin
    store.valid = (state == stStore) && (insn.kind != kindJp);
    store.dst   = insn.dst;
    store.value = idb;
  end

  // DR touched by the program, host must service it
  assign rqmSet = store.valid && ((isOp && insn.src == regDrSrc) || insn.dst == regDr);

  stateOneHot: assert property (@(posedge CLK) disable iff (rst) $onehot(state));

endmodule

`default_nettype wire

//--- source/upd77c25Alu.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25Alu import upd77c25Pkg::*; (
  input  wire logic                 CLK,
  input  wire logic                 rst,
  input  wire logic [wordWidth-1:0] idb,
  input  wire insn_t                insn,
  input  wire logic                 phaseExec,
  input  wire logic                 phaseNext,
  input  wire dstWrite_t            store,
  output logic      [wordWidth-1:0] accA,
  output logic      [wordWidth-1:0] accB,
  output logic      [wordWidth-1:0] tr,
  output aluFlags_t                 flagsA,
  output aluFlags_t                 flagsB
);

  logic [wordWidth-1:0] aluP;    // operand from bus or 1
  logic [wordWidth-1:0] aluQ;    // operand from accumulator
  logic [wordWidth-1:0] aluR;
  logic                 carry;
  logic                 aluOk;   // supported op on OP/RT
  logic                 blockWb; // STORE hit the target acc
  aluFlags_t            newFlags;
  regSel_t              accSel;

  assign accSel = insn.asl ? regB : regA;

  ////////////////////
  // operand latches
  always_ff @(posedge CLK) begin
    if (phaseExec) begin
      aluQ <= insn.asl ? accB : accA;
      if (insn.alu == aluInc || insn.alu == aluDec) aluP <= 16'h0001;
      else aluP <= idb; // no multiplier, P is always the bus
    end
  end

  always_comb begin
    aluR  = aluQ;
    carry = 1'b0; // logic ops clear C
    aluOk = 1'b1;
    case (insn.alu)
      aluOr:  aluR = aluQ | aluP;
      aluAnd: aluR = aluQ & aluP;
      aluXor: aluR = aluQ ^ aluP;
      aluNot: aluR = ~aluQ;
      aluSub, aluDec: begin
        aluR  = aluQ - aluP;
        carry = aluR > aluQ; // borrow
      end
      aluAdd, aluInc: begin
        aluR  = aluQ + aluP;
        carry = aluR < aluQ;
      end
      aluShr1: begin
        aluR  = {aluQ[wordWidth-1], aluQ[wordWidth-1:1]};
        carry = aluQ[0];
      end
      default: aluOk = 1'b0;
    endcase
    if (insn.kind == kindJp || insn.kind == kindLd) aluOk = 1'b0;
  end

  assign newFlags = '{c: carry, z: (aluR == '0), s0: aluR[wordWidth-1]};

  // remembered from STORE for the NEXT write-back
  always_ff @(posedge CLK) begin
    if (rst) blockWb <= 1'b0;
    else blockWb <= store.valid && store.dst == accSel;
  end

  ////////////////////
  // registers
  always_ff @(posedge CLK) begin
    if (rst) begin
      accA   <= '0;
      accB   <= '0;
      tr     <= '0;
      flagsA <= '0;
      flagsB <= '0;
    end else if (store.valid) begin
      case (store.dst)
        regA:    accA <= store.value;
        regB:    accB <= store.value;
        regTr:   tr <= store.value;
        default: ; // DR / SR live in the host port
      endcase
    end else if (phaseNext && aluOk && !blockWb) begin
      if (insn.asl) begin
        accB   <= aluR;
        flagsB <= newFlags;
      end else begin
        accA   <= aluR;
        flagsA <= newFlags;
      end
    end
  end

  // STORE is the cycle right after EXEC
  accWriteWindow: assert property (@(posedge CLK) disable iff (rst)
    ($changed(accA) || $changed(accB)) |->
      ($past(phaseNext) || $past(phaseExec, 2) || $past(rst)));

endmodule

`default_nettype wire

//--- source/upd77c25.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25 import upd77c25Pkg::*; #(
  parameter int pgmAddrWidth = 11
) (
  input  wire logic                    CLK,
  input  wire logic                    rst,
  input  wire logic                    enable,
  input  wire logic                    a0,
  input  wire logic                    regWeRising,
  input  wire logic                    regOeRising,
  input  wire logic [7:0]              dataIn,
  input  wire logic                    pgmWr,
  input  wire logic [pgmAddrWidth-1:0] pgmAddr,
  input  wire insn_t                   pgmData,
  output logic      [7:0]              dataOut
);

  insn_t                   insnRaw;
  insn_t                   insn;     // latched in FETCH
  logic [pgmAddrWidth-1:0] pc;
  logic [wordWidth-1:0]    idb;
  logic [wordWidth-1:0]    accA;
  logic [wordWidth-1:0]    accB;
  logic [wordWidth-1:0]    tr;
  logic [wordWidth-1:0]    dr;
  logic [wordWidth-1:0]    sr;
  aluFlags_t               flagsA;
  dstWrite_t               store;
  logic                    phaseExec;
  logic                    phaseNext;
  logic                    rqmSet;

  ////////////////////
  upd77c25PgmRom #(.pgmAddrWidth(pgmAddrWidth)) pgmRom (
    .CLK, .pgmWr, .pgmAddr, .pgmData, .pc, .insn(insnRaw)
  );

  upd77c25HostPort hostPort (
    .CLK, .rst, .enable, .a0, .regWeRising, .regOeRising, .dataIn,
    .store, .rqmSet, .dataOut, .dr, .sr
  );

  upd77c25Sequencer #(.pgmAddrWidth(pgmAddrWidth)) sequencer (
    .CLK, .rst, .insnRaw, .accA, .accB, .tr, .dr, .sr, .flagsA,
    .pc, .insn, .idb, .phaseExec, .phaseNext, .store, .rqmSet
  );

  // B flags have no branch in this core
  upd77c25Alu alu (
    .CLK, .rst, .idb, .insn, .phaseExec, .phaseNext, .store,
    .accA, .accB, .tr, .flagsA, .flagsB()
  );

endmodule

`default_nettype wire

//--- testbench/upd77c25Tb.sv
`timescale 1ns/1ps
`default_nettype none

module upd77c25Tb import upd77c25Pkg::*; ();

  localparam int pgmAddrWidth = 11;
  localparam int progLen      = 16;
  localparam int rqmTimeout   = 200; // SR polls per wait

  logic                    CLK;
  logic                    rst;
  logic                    enable;
  logic                    a0;
  logic                    regWeRising;
  logic                    regOeRising;
  logic [7:0]              dataIn;
  logic                    pgmWr;
  logic [pgmAddrWidth-1:0] pgmAddr;
  insn_t                   pgmData;
  logic [7:0]              dataOut;

  insn_t       progMem [progLen]; // test program image
  logic [15:0] rngState;
  int          valueErrors = 0;
  int          timeouts    = 0;
  int          cycleCount  = 0;

  upd77c25 #(.pgmAddrWidth(pgmAddrWidth)) dut (
    .CLK, .rst, .enable, .a0, .regWeRising, .regOeRising, .dataIn,
    .pgmWr, .pgmAddr, .pgmData, .dataOut
  );

  always #20 CLK = ~CLK; // 40 ns period

  always @(posedge CLK) cycleCount <= cycleCount + 1; // timestamps for RQM rises

  ////////////////////
  // SR high byte only ever shows RQM, DRS and DRC
  srSpareBits: assert property (@(posedge CLK) disable iff (rst)
    a0 |-> (dataOut & 8'h6B) == 8'h00)
  else begin
    valueErrors++;
    $display("FAILED at %0t: dataOut = %h, expected %h", $time,
             $sampled(dataOut), $sampled(dataOut) & 8'h94);
  end

  // 8-bit mode, DRS must stay put
  drsIdleInByteMode: assert property (@(posedge CLK) disable iff (rst)
    (a0 && dataOut[2]) |-> !dataOut[4])
  else begin
    valueErrors++;
    $display("FAILED at %0t: dataOut[4] (DRS) = 1, expected 0 with DRC set", $time);
  end

  ////////////////////
  function automatic logic [15:0] xorshift(input logic [15:0] s);
    logic [15:0] v;
    v = s;
    v ^= v << 7;
    v ^= v >> 9;
    v ^= v << 8;
    return v;
  endfunction

  // OP word, always on accumulator A
  function automatic insn_t opWord(input aluOp_t op, input regSel_t src, input regSel_t dst);
    insn_t w;
    w      = '0;
    w.kind = kindOp;
    w.alu  = op;
    w.src  = src;
    w.dst  = dst;
    return w;
  endfunction

  function automatic insn_t ldWord(input logic [15:0] id, input regSel_t dst);
    ldView_t w;
    w      = '0;
    w.kind = kindLd;
    w.id   = id;
    w.dst  = dst;
    return insn_t'(w);
  endfunction

  function automatic insn_t jpWord(input jumpCond_t cond, input int target);
    jpView_t w;
    w      = '0;
    w.kind = kindJp;
    w.brch = cond;
    w.na   = 11'(target);
    return insn_t'(w);
  endfunction

  task automatic buildProgram(input logic [15:0] y);
    progMem[0]  = ldWord(16'h1234, regDr);
    progMem[1]  = jpWord(condJrqm, 1);           // spin until host drains DR
    progMem[2]  = opWord(aluNone, regDrSrc, regA); // A = X
    progMem[3]  = ldWord(y, regB);
    progMem[4]  = opWord(aluAdd, regB, regNon);  // A = X + Y
    progMem[5]  = jpWord(condJnca, 7);           // no carry skips the TR load
    progMem[6]  = ldWord(16'hC0DE, regTr);
    progMem[7]  = opWord(aluNone, regA, regDr);
    progMem[8]  = jpWord(condJrqm, 8);
    progMem[9]  = opWord(aluXor, regA, regNon);  // A ^ A, Z path
    progMem[10] = opWord(aluNone, regA, regDr);
    progMem[11] = jpWord(condJrqm, 11);
    progMem[12] = ldWord(16'h0001 << srDrc, regSr); // 8-bit transfers from here
    progMem[13] = ldWord(16'h00AB, regDr);
    progMem[14] = jpWord(condJrqm, 14);
    progMem[15] = jpWord(condJmp, 15);           // park
  endtask

  ////////////////////
  // host tasks, entered on a falling edge, one byte per cycle
  task automatic readByte(input logic selSr, output logic [7:0] data);
    a0          = selSr;
    enable      = 1'b1;
    regOeRising = 1'b1;
    #5 data = dataOut; // mid low phase, settled
    @(negedge CLK);
    regOeRising = 1'b0;
    enable      = 1'b0;
  endtask

  task automatic writeByte(input logic [7:0] data);
    a0          = 1'b0;
    enable      = 1'b1;
    regWeRising = 1'b1;
    dataIn      = data;
    @(negedge CLK);
    regWeRising = 1'b0;
    enable      = 1'b0;
  endtask

  task automatic readWord(output logic [15:0] word);
    logic [7:0] lo;
    logic [7:0] hi;
    readByte(1'b0, lo); // low byte first
    readByte(1'b0, hi);
    word = {hi, lo};
  endtask

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else begin
      valueErrors++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("errors: %0d wrong values, %0d timeouts", valueErrors, timeouts);
    if (valueErrors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // poll SR every cycle until RQM, seenAt is the cycle it showed up
  task automatic waitRqm(input logic checkIdle, output logic [7:0] srByte, output int seenAt);
    int polls;
    polls = 0;
    readByte(1'b1, srByte);
    while (!srByte[7] && polls < rqmTimeout) begin
      if (checkIdle) checkValue("SR while idle", 16'(srByte), 16'h0000);
      polls++;
      readByte(1'b1, srByte);
    end
    seenAt = cycleCount;
    if (!srByte[7]) begin
      timeouts++;
      $display("timeout: RQM stayed low for %0d SR polls", rqmTimeout);
      finishRun();
    end
  endtask

  ////////////////////
  initial begin
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  srByte;
    logic [15:0] word;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] sum;
    logic        carry;
    int          seenAt;
    int          firstSeen;
    int          secondSeen;
    CLK         = 1'b0;
    rst         = 1'b1;
    enable      = 1'b0;
    a0          = 1'b0;
    regWeRising = 1'b0;
    regOeRising = 1'b0;
    dataIn      = 8'h00;
    pgmWr       = 1'b0;
    pgmAddr     = '0;
    pgmData     = '0;
    rngState    = 16'd78;
    rngState    = xorshift(rngState);
    y           = rngState; // baked into the program
    rngState    = xorshift(rngState);
    x           = rngState; // sent by the host
    buildProgram(y);

    // program load while in reset
    for (int i = 0; i < progLen; i++) begin
      @(negedge CLK);
      pgmWr   = 1'b1;
      pgmAddr = pgmAddrWidth'(i);
      pgmData = progMem[i];
    end
    @(negedge CLK);
    pgmWr = 1'b0;
    repeat (4) @(negedge CLK);
    rst = 1'b0;

    // first DR word, 16-bit mode
    waitRqm(1'b1, srByte, seenAt);
    checkValue("SR", 16'(srByte), 16'h0080);
    readByte(1'b0, lo);
    readByte(1'b1, srByte);
    checkValue("SR after low byte", 16'(srByte), 16'h0090); // DRS up
    readByte(1'b0, hi);
    checkValue("DR", {hi, lo}, 16'h1234);

    // X lands before the program reads DR
    writeByte(x[7:0]);
    writeByte(x[15:8]);
    waitRqm(1'b1, srByte, firstSeen); // DR consumed
    readWord(word);
    checkValue("DR echo", word, x);
    waitRqm(1'b1, srByte, secondSeen);
    readWord(word);
    sum   = x + y;
    carry = sum < x;
    checkValue("DR sum", word, sum);
    // carry runs the TR load, one more instruction before the result
    checkValue("RQM gap cycles", 16'(secondSeen - firstSeen), carry ? 16'd25 : 16'd20);

    waitRqm(1'b1, srByte, seenAt);
    readWord(word);
    checkValue("DR after XOR", word, 16'h0000);

    // DRC set by the program, single byte transfer
    waitRqm(1'b0, srByte, seenAt);
    checkValue("SR", 16'(srByte), 16'h0084);
    readByte(1'b0, lo);
    checkValue("DR byte", 16'(lo), 16'h00AB);
    readByte(1'b1, srByte);
    checkValue("SR after one byte", 16'(srByte), 16'h0004); // RQM gone
    finishRun();
  end

endmodule

`default_nettype wire

//--- src.f
source/upd77c25Pkg.sv
source/upd77c25PgmRom.sv
source/upd77c25HostPort.sv
source/upd77c25Sequencer.sv
source/upd77c25Alu.sv
source/upd77c25.sv
testbench/upd77c25Tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module upd77c25Tb -o simv
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
